// File: prefetch_macros.svh
////////////////////////////////////////////////////////////////////////////
// address, line and stride table widths shared by the prefetch unit
////////////////////////////////////////////////////////////////////////////
`ifndef PREFETCH_MACROS_SVH
`define PREFETCH_MACROS_SVH

// byte address width
`define PREF_ADDR_W 32

// 32-byte lines
`define PREF_LINE_OFS 5
`define PREF_LINE_W (`PREF_ADDR_W - `PREF_LINE_OFS)

// stride table index from pc bits above the word offset
`define PREF_IDX_W 4

// pc tag from the pc bits above the index
`define PREF_TAG_W (`PREF_ADDR_W - `PREF_IDX_W - 2)

// signed stride in lines
`define PREF_STRIDE_W 12

`endif

// File: pref_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// L2 prefetch port types for line number, request kind and issue FSM states
////////////////////////////////////////////////////////////////////////////
`include "prefetch_macros.svh"

package pref_bus_pkg;

    typedef logic [`PREF_LINE_W-1:0] line_t;

    // same encoding as the l2 type wire
    typedef enum logic {
        KIND_INST = 1'b0,
        KIND_DATA = 1'b1
    } pref_kind_e;

    typedef enum logic [1:0] {
        ISSUE_IDLE = 2'd0,
        ISSUE_REQ  = 2'd1,
        ISSUE_WAIT = 2'd2
    } issue_state_e;

    // line number back to a line-aligned byte address
    function automatic logic [`PREF_ADDR_W-1:0] line_to_addr(line_t line);
        return {line, {`PREF_LINE_OFS{1'b0}}};
    endfunction

endpackage

// File: pref_table_pkg.sv
////////////////////////////////////////////////////////////////////////////
// stride table entry and confidence states
////////////////////////////////////////////////////////////////////////////
`include "prefetch_macros.svh"

package pref_table_pkg;

    typedef enum logic [1:0] {
        CONF_NONE   = 2'd0,
        CONF_WEAK   = 2'd1,
        CONF_STEADY = 2'd2,
        CONF_STRONG = 2'd3
    } conf_e;

    typedef struct packed {
        logic                             valid;
        logic [`PREF_TAG_W-1:0]           tag;
        pref_bus_pkg::line_t              last_line;
        logic signed [`PREF_STRIDE_W-1:0] stride;
        conf_e                            conf;
    } stride_entry_t;

endpackage

// File: pref_req_if.sv
////////////////////////////////////////////////////////////////////////////
// pending prefetch from one predictor to the issue arbiter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

interface pref_req_if;
    import pref_bus_pkg::*;

    logic       valid;
    logic       ready;
    line_t      line;
    pref_kind_e kind;

    // transfer on an edge with valid and ready both high
    modport source (
        output valid, line, kind,
        input  ready
    );

    modport sink (
        input  valid, line, kind,
        output ready
    );

endinterface

// File: next_line_pred.sv
////////////////////////////////////////////////////////////////////////////
// next-line instruction predictor with duplicate filter and pending slot
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module next_line_pred (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`PREF_ADDR_W-1:0] fetch_addr,
    input  logic                    fetch_valid,
    pref_req_if.source              req
);
    import pref_bus_pkg::*;

    line_t fetch_line;
    line_t last_line;
    logic  last_vld;
    logic  new_line;

    assign fetch_line = fetch_addr[`PREF_ADDR_W-1:`PREF_LINE_OFS];

    // repeated fetches in one line are filtered
    assign new_line = fetch_valid && (!last_vld || fetch_line != last_line);

    assign req.kind = KIND_INST;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_vld  <= 1'b0;
            req.valid <= 1'b0;
        end else begin
            if (new_line) begin
                last_vld  <= 1'b1;
                last_line <= fetch_line;
            end
            // newest prediction overwrites the waiting one
            if (new_line) begin
                req.valid <= 1'b1;
                req.line  <= fetch_line + line_t'(1);
            end else if (req.ready) begin
                req.valid <= 1'b0;
            end
        end
    end

    // a waiting line is only replaced by a newer prediction
    a_pending_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        req.valid && !req.ready && !new_line
        |=> req.valid && $stable(req.line) && $stable(req.kind)
    );

endmodule

// File: stride_pred.sv
////////////////////////////////////////////////////////////////////////////
// pc-indexed stride predictor with a sixteen-entry confidence table
// and one pending prefetch slot
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module stride_pred (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`PREF_ADDR_W-1:0] dc_addr,
    input  logic [`PREF_ADDR_W-1:0] dc_pc,
    input  logic                    dc_valid,
    pref_req_if.source              req
);
    import pref_bus_pkg::*;
    import pref_table_pkg::*;

    localparam int ENTRIES = 1 << `PREF_IDX_W;

    stride_entry_t                    tbl [ENTRIES];
    stride_entry_t                    cur;
    stride_entry_t                    upd;
    logic [`PREF_IDX_W-1:0]           idx;
    logic [`PREF_TAG_W-1:0]           tag;
    line_t                            acc_line;
    line_t                            delta;
    line_t                            pred_line;
    logic signed [`PREF_STRIDE_W-1:0] delta_s;
    logic                             delta_fits;
    logic                             hit;
    logic                             match;
    logic                             post;

    assign idx      = dc_pc[`PREF_IDX_W+1:2];
    assign tag      = dc_pc[`PREF_ADDR_W-1:`PREF_IDX_W+2];
    assign acc_line = dc_addr[`PREF_ADDR_W-1:`PREF_LINE_OFS];

    assign cur = tbl[idx];
    assign hit = cur.valid && (cur.tag == tag);

    // line delta wrapped to line width and checked for 12-bit range
    assign delta      = acc_line - cur.last_line;
    assign delta_fits = (&delta[`PREF_LINE_W-1:`PREF_STRIDE_W-1]) ||
                        !(|delta[`PREF_LINE_W-1:`PREF_STRIDE_W-1]);
    assign delta_s    = delta_fits ? delta[`PREF_STRIDE_W-1:0] : '0;

    assign match = hit && (cur.stride != '0) && (delta_s == cur.stride);

    always_comb begin
        upd           = cur;
        upd.valid     = 1'b1;
        upd.tag       = tag;
        upd.last_line = acc_line;
        if (!hit) begin
            upd.stride = '0;
            upd.conf   = CONF_NONE;
        end else if (match) begin
            case (cur.conf)
                CONF_NONE: upd.conf = CONF_WEAK;
                CONF_WEAK: upd.conf = CONF_STEADY;
                default:   upd.conf = CONF_STRONG;
            endcase
        end else begin
            upd.stride = delta_s;
            // first stride after allocation counts as one sighting
            if (cur.stride == '0 && delta_s != '0) begin
                upd.conf = CONF_WEAK;
            end else begin
                upd.conf = CONF_NONE;
            end
        end
    end

    assign post = dc_valid && (upd.conf >= CONF_STEADY);

    // access line plus sign-extended stride
    assign pred_line = acc_line +
        {{(`PREF_LINE_W-`PREF_STRIDE_W){upd.stride[`PREF_STRIDE_W-1]}}, upd.stride};

    assign req.kind = KIND_DATA;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                tbl[i].valid <= 1'b0;
            end
            req.valid <= 1'b0;
        end else begin
            if (dc_valid) begin
                tbl[idx] <= upd;
            end
            if (post) begin
                req.valid <= 1'b1;
                req.line  <= pred_line;
            end else if (req.ready) begin
                req.valid <= 1'b0;
            end
        end
    end

    // waiting line survives back-pressure until a newer prediction
    a_pending_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        req.valid && !req.ready && !post
        |=> req.valid && $stable(req.line) && $stable(req.kind)
    );

endmodule

// File: pref_issue_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// fixed-priority arbiter, L2 prefetch issue FSM and statistics counters
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module pref_issue_arbiter (
    input  logic                    clk,
    input  logic                    rstn,
    pref_req_if.sink                inst_req,
    pref_req_if.sink                data_req,
    output logic                    l2_req,
    output logic                    l2_type,
    output logic [`PREF_ADDR_W-1:0] l2_addr,
    input  logic                    l2_addr_ok,
    input  logic                    l2_complete,
    input  logic                    l2_hit,
    output logic [31:0]             stat_issued,
    output logic [31:0]             stat_hit
);
    import pref_bus_pkg::*;

    issue_state_e state;
    issue_state_e state_nxt;
    line_t        line_q;
    pref_kind_e   kind_q;
    logic         idle;
    logic         grant_inst;
    logic         grant_data;

    assign idle = (state == ISSUE_IDLE);

    // instruction side wins when both are pending
    assign grant_inst = idle && inst_req.valid;
    assign grant_data = idle && data_req.valid && !inst_req.valid;

    assign inst_req.ready = idle && !grant_data;
    assign data_req.ready = grant_data;

    always_comb begin
        case (state)
            ISSUE_IDLE: begin
                state_nxt = (grant_inst || grant_data) ? ISSUE_REQ : ISSUE_IDLE;
            end
            ISSUE_REQ: begin
                if (l2_addr_ok) begin
                    state_nxt = l2_complete ? ISSUE_IDLE : ISSUE_WAIT;
                end else begin
                    state_nxt = ISSUE_REQ;
                end
            end
            ISSUE_WAIT: begin
                state_nxt = l2_complete ? ISSUE_IDLE : ISSUE_WAIT;
            end
            default: state_nxt = ISSUE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ISSUE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // capture the granted line
    always_ff @(posedge clk) begin
        if (grant_inst) begin
            line_q <= inst_req.line;
            kind_q <= inst_req.kind;
        end else if (grant_data) begin
            line_q <= data_req.line;
            kind_q <= data_req.kind;
        end
    end

    assign l2_req  = !idle;
    assign l2_type = kind_q;
    assign l2_addr = line_to_addr(line_q);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stat_issued <= '0;
            stat_hit    <= '0;
        end else if (l2_req && l2_complete) begin
            stat_issued <= stat_issued + 32'd1;
            if (l2_hit) begin
                stat_hit <= stat_hit + 32'd1;
            end
        end
    end

    a_req_held: assert property (
        @(posedge clk) disable iff (!rstn)
        l2_req && !l2_complete |=> l2_req
    );

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        l2_req && !l2_complete |=> $stable(l2_addr) && $stable(l2_type)
    );

    a_one_ready: assert property (
        @(posedge clk) disable iff (!rstn)
        !(inst_req.ready && data_req.ready)
    );

endmodule

// File: prefetch_top.sv
////////////////////////////////////////////////////////////////////////////
// prefetch unit top with next-line and stride predictors sharing one
// L2 prefetch port through the issue arbiter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module prefetch_top (
    input  logic                    clk,
    input  logic                    rstn,
    // instruction fetch side
    input  logic [`PREF_ADDR_W-1:0] fetch_addr,
    input  logic                    fetch_valid,
    // data cache accesses
    input  logic [`PREF_ADDR_W-1:0] dc_addr,
    input  logic [`PREF_ADDR_W-1:0] dc_pc,
    input  logic                    dc_valid,
    // L2 prefetch port
    output logic                    l2_req,
    output logic                    l2_type,
    output logic [`PREF_ADDR_W-1:0] l2_addr,
    input  logic                    l2_addr_ok,
    input  logic                    l2_complete,
    input  logic                    l2_hit,
    output logic [31:0]             stat_issued,
    output logic [31:0]             stat_hit
);

    pref_req_if inst_if ();
    pref_req_if data_if ();

    next_line_pred u_next_line_pred (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .req         (inst_if.source)
    );

    stride_pred u_stride_pred (
        .clk      (clk),
        .rstn     (rstn),
        .dc_addr  (dc_addr),
        .dc_pc    (dc_pc),
        .dc_valid (dc_valid),
        .req      (data_if.source)
    );

    pref_issue_arbiter u_pref_issue_arbiter (
        .clk         (clk),
        .rstn        (rstn),
        .inst_req    (inst_if.sink),
        .data_req    (data_if.sink),
        .l2_req      (l2_req),
        .l2_type     (l2_type),
        .l2_addr     (l2_addr),
        .l2_addr_ok  (l2_addr_ok),
        .l2_complete (l2_complete),
        .l2_hit      (l2_hit),
        .stat_issued (stat_issued),
        .stat_hit    (stat_hit)
    );

endmodule

// File: tb_clock.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock generator with a 4 ns period
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #2 clk = ~clk;

endmodule

// File: tb_prefetch.sv
////////////////////////////////////////////////////////////////////////////
// prefetch unit testbench with directed and random stimulus, reference
// model, L2 responder and watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module tb_prefetch;

    localparam int          RAND_CYCLES = 3000;
    localparam int          TEST_CYCLES = RAND_CYCLES + 400;
    localparam int          DRAIN_LIMIT = 200;
    localparam int          M_IDLE      = 0;
    localparam int          M_REQ       = 1;
    localparam int          M_WAIT      = 2;
    localparam int          RS_IDLE     = 0;
    localparam int          RS_ADDR     = 1;
    localparam int          RS_DATA     = 2;
    localparam int          RS_COOL     = 3;
    localparam logic [31:0] PC          = 32'h0000_4a10;
    localparam logic [31:0] BASE        = 32'h0010_0000;

    logic                    clk;
    logic                    rstn        = 1'b0;
    logic [`PREF_ADDR_W-1:0] fetch_addr  = '0;
    logic                    fetch_valid = 1'b0;
    logic [`PREF_ADDR_W-1:0] dc_addr     = '0;
    logic [`PREF_ADDR_W-1:0] dc_pc       = '0;
    logic                    dc_valid    = 1'b0;
    logic                    l2_req;
    logic                    l2_type;
    logic [`PREF_ADDR_W-1:0] l2_addr;
    logic                    l2_addr_ok  = 1'b0;
    logic                    l2_complete = 1'b0;
    logic                    l2_hit      = 1'b0;
    logic [31:0]             stat_issued;
    logic [31:0]             stat_hit;

    // reference model state
    int                      m_state;
    logic [`PREF_LINE_W-1:0] m_line;
    logic                    m_kind;
    logic                    m_new;
    logic                    pend_v [2];
    logic [`PREF_LINE_W-1:0] pend_l [2];
    logic                    nl_vld;
    logic [`PREF_LINE_W-1:0] nl_last;
    logic                    t_valid  [16];
    logic [`PREF_TAG_W-1:0]  t_tag    [16];
    logic [`PREF_LINE_W-1:0] t_last   [16];
    int                      t_stride [16];
    int                      t_conf   [16];

    // L2 responder and request log
    int                      rs_phase;
    int                      ok_dly;
    int                      cpl_dly;
    int                      cpl_cnt = 0;
    int                      hit_cnt = 0;
    int                      mark    = 0;
    logic [31:0]             log_addr [$];
    logic                    log_type [$];

    tb_clock u_tb_clock (.clk(clk));

    prefetch_top u_prefetch_top (.*);

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic fail_value(string msg);
        abort_run($sformatf("FAIL @%0t ns: %s", $time, msg));
    endtask

    always @(posedge clk) begin : model
        logic [`PREF_LINE_W-1:0]        fl;
        logic [`PREF_LINE_W-1:0]        acc;
        logic signed [`PREF_LINE_W-1:0] dl;
        logic [`PREF_TAG_W-1:0]         tg;
        logic [3:0]                     ix;
        logic                           gi;
        logic                           gd;
        int                             d;
        int                             ns;
        int                             nc;
        if (!rstn) begin
            m_state   = M_IDLE;
            m_new     = 1'b0;
            nl_vld    = 1'b0;
            pend_v[0] = 1'b0;
            pend_v[1] = 1'b0;
            for (int i = 0; i < 16; i++) begin
                t_valid[i] = 1'b0;
            end
        end else begin
            assert (l2_req === (m_state != M_IDLE))
                else fail_value($sformatf("l2_req is %b in model state %0d", l2_req, m_state));
            if (m_state != M_IDLE) begin
                assert (l2_addr === {m_line, {`PREF_LINE_OFS{1'b0}}} && l2_type === m_kind)
                    else fail_value($sformatf("l2_addr %h type %b, expected %h type %b",
                        l2_addr, l2_type, {m_line, {`PREF_LINE_OFS{1'b0}}}, m_kind));
            end
            if (m_new) begin
                log_addr.push_back(l2_addr);
                log_type.push_back(l2_type);
                m_new = 1'b0;
            end
            // arbiter with the instruction side first
            gi = (m_state == M_IDLE) && pend_v[0];
            gd = (m_state == M_IDLE) && !pend_v[0] && pend_v[1];
            if (gi || gd) begin
                m_line  = gi ? pend_l[0] : pend_l[1];
                m_kind  = gd;
                m_state = M_REQ;
                m_new   = 1'b1;
            end else if (m_state == M_REQ && l2_addr_ok) begin
                m_state = l2_complete ? M_IDLE : M_WAIT;
            end else if (m_state == M_WAIT && l2_complete) begin
                m_state = M_IDLE;
            end
            // next-line rule
            fl = fetch_addr[`PREF_ADDR_W-1:`PREF_LINE_OFS];
            if (fetch_valid && (!nl_vld || fl != nl_last)) begin
                nl_vld    = 1'b1;
                nl_last   = fl;
                pend_v[0] = 1'b1;
                pend_l[0] = fl + 1;
            end else if (gi) begin
                pend_v[0] = 1'b0;
            end
            // stride table
            ix  = dc_pc[5:2];
            tg  = dc_pc[`PREF_ADDR_W-1:6];
            acc = dc_addr[`PREF_ADDR_W-1:`PREF_LINE_OFS];
            nc  = 0;
            if (dc_valid) begin
                ns = 0;
                if (t_valid[ix] && t_tag[ix] == tg) begin
                    dl = acc - t_last[ix];
                    d  = int'(dl);
                    if (d < -2048 || d > 2047) begin
                        d = 0;
                    end
                    if (t_stride[ix] != 0 && d == t_stride[ix]) begin
                        ns = d;
                        nc = (t_conf[ix] < 3) ? t_conf[ix] + 1 : 3;
                    end else begin
                        ns = d;
                        nc = (t_stride[ix] == 0 && d != 0) ? 1 : 0;
                    end
                end
                t_valid[ix]  = 1'b1;
                t_tag[ix]    = tg;
                t_last[ix]   = acc;
                t_stride[ix] = ns;
                t_conf[ix]   = nc;
            end
            if (dc_valid && nc >= 2) begin
                pend_v[1] = 1'b1;
                pend_l[1] = acc + ns[`PREF_LINE_W-1:0];
            end else if (gd) begin
                pend_v[1] = 1'b0;
            end
        end
    end

    // L2 responder with address accept after 0..3 cycles and completion 0..5 later
    always @(posedge clk) begin : responder
        logic hit;
        l2_addr_ok  <= 1'b0;
        l2_complete <= 1'b0;
        l2_hit      <= 1'b0;
        if (!rstn) begin
            rs_phase = RS_IDLE;
        end else begin
            if (rs_phase == RS_COOL) begin
                rs_phase = RS_IDLE;
            end else if (rs_phase == RS_IDLE && l2_req) begin
                ok_dly   = $urandom_range(0, 3);
                cpl_dly  = $urandom_range(0, 5);
                rs_phase = RS_ADDR;
            end
            if (rs_phase == RS_ADDR) begin
                if (ok_dly == 0) begin
                    l2_addr_ok <= 1'b1;
                    rs_phase = RS_DATA;
                end else begin
                    ok_dly--;
                end
            end else if (rs_phase == RS_DATA) begin
                cpl_dly--;
            end
            if (rs_phase == RS_DATA && cpl_dly == 0) begin
                hit = ($urandom_range(0, 1) == 1);
                l2_complete <= 1'b1;
                l2_hit      <= hit;
                cpl_cnt++;
                if (hit) begin
                    hit_cnt++;
                end
                rs_phase = RS_COOL;
            end
        end
    end

    task automatic pulse(logic f, logic d, logic [31:0] fa, logic [31:0] pc, logic [31:0] da);
        @(posedge clk);
        fetch_valid <= f;
        fetch_addr  <= fa;
        dc_valid    <= d;
        dc_pc       <= pc;
        dc_addr     <= da;
        @(posedge clk);
        fetch_valid <= 1'b0;
        dc_valid    <= 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        repeat (3) @(negedge clk);
        while (l2_req || m_state != M_IDLE || pend_v[0] || pend_v[1]) begin
            @(negedge clk);
            n++;
            assert (n < DRAIN_LIMIT)
                else abort_run("prefetch port did not go idle within the drain limit");
        end
    endtask

    task automatic expect_issues(int n, logic typ, logic [31:0] addr);
        wait_drained();
        assert (log_addr.size() == mark + n)
            else fail_value($sformatf("%0d requests issued, expected %0d",
                log_addr.size() - mark, n));
        if (n > 0) begin
            assert (log_addr[$] == addr && log_type[$] == typ)
                else fail_value($sformatf("request %h type %b, expected %h type %b",
                    log_addr[$], log_type[$], addr, typ));
        end
        mark = log_addr.size();
    endtask

    task automatic run_random(int cycles);
        logic [31:0] f_addr;
        logic [31:0] d_addr [4];
        int          d_stride [4];
        logic [31:0] pcs [4];
        logic        dv;
        int          p;
        pcs[0] = 32'h0000_0104;
        pcs[1] = 32'h0000_0208;
        pcs[2] = 32'h0000_0330;
        // same index as pcs[0] so entries get evicted
        pcs[3] = 32'h0000_0444;
        f_addr = 32'h0040_0000;
        for (int k = 0; k < 4; k++) begin
            d_addr[k]   = 32'h0100_0000 + (k << 20);
            d_stride[k] = k + 1;
        end
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            f_addr = ($urandom_range(0, 7) == 0) ? $urandom : f_addr + 4;
            fetch_addr  <= f_addr;
            fetch_valid <= ($urandom_range(0, 2) != 0);
            p  = $urandom_range(0, 3);
            dv = ($urandom_range(0, 1) == 1);
            if (dv) begin
                if ($urandom_range(0, 15) == 0) begin
                    d_stride[p] = int'($urandom_range(0, 16)) - 8;
                end
                d_addr[p] = ($urandom_range(0, 63) == 0) ? $urandom :
                            d_addr[p] + d_stride[p] * 32;
            end
            dc_pc    <= pcs[p];
            dc_addr  <= d_addr[p];
            dc_valid <= dv;
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
        dc_valid    <= 1'b0;
    endtask

    initial begin : watchdog
        repeat (TEST_CYCLES * 20 + 2000) @(posedge clk);
        abort_run($sformatf("watchdog: run did not end within %0d cycles",
            TEST_CYCLES * 20 + 2000));
    end

    initial begin
        void'($urandom(32'hab63_b317));
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (l2_req === 1'b0 && stat_issued === 32'd0 && stat_hit === 32'd0)
            else fail_value("port busy or counters nonzero after reset");

        // next-line requests with same-line fetches filtered
        pulse(1'b1, 1'b0, 32'h0000_1000, 0, 0);
        expect_issues(1, 1'b0, 32'h0000_1020);
        pulse(1'b1, 1'b0, 32'h0000_1004, 0, 0);
        expect_issues(0, 1'b0, 0);
        pulse(1'b1, 1'b0, 32'h0000_101c, 0, 0);
        expect_issues(0, 1'b0, 0);
        pulse(1'b1, 1'b0, 32'h0000_2040, 0, 0);
        expect_issues(1, 1'b0, 32'h0000_2060);
        pulse(1'b1, 1'b0, 32'h0000_2044, 0, 0);
        expect_issues(0, 1'b0, 0);
        pulse(1'b1, 1'b0, 32'h0000_1000, 0, 0);
        expect_issues(1, 1'b0, 32'h0000_1020);

        // stride of 3 lines then broken to 10 lines and retrained
        for (int k = 0; k < 5; k++) begin
            pulse(1'b0, 1'b1, 0, PC, BASE + k * 96);
            expect_issues((k >= 2) ? 1 : 0, 1'b1, BASE + (k + 1) * 96);
        end
        for (int k = 1; k <= 3; k++) begin
            pulse(1'b0, 1'b1, 0, PC, BASE + 4 * 96 + k * 320);
            expect_issues((k == 3) ? 1 : 0, 1'b1, BASE + 4 * 96 + (k + 1) * 320);
        end

        // instruction request goes first when fetch and confident access coincide
        pulse(1'b1, 1'b1, 32'h0000_3000, PC, BASE + 4 * 96 + 4 * 320);
        expect_issues(2, 1'b1, BASE + 4 * 96 + 5 * 320);
        assert (log_addr[log_addr.size()-2] == 32'h0000_3020 &&
                log_type[log_type.size()-2] == 1'b0)
            else fail_value("instruction request not issued ahead of data request");

        run_random(RAND_CYCLES);
        wait_drained();
        assert (stat_issued === cpl_cnt && stat_hit === hit_cnt && log_addr.size() == cpl_cnt)
            else fail_value($sformatf("stat_issued %0d stat_hit %0d, expected %0d and %0d",
                stat_issued, stat_hit, cpl_cnt, hit_cnt));

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: prefetch.f
+incdir+.
pref_bus_pkg.sv
pref_table_pkg.sv
pref_req_if.sv
next_line_pred.sv
stride_pred.sv
pref_issue_arbiter.sv
prefetch_top.sv
tb_clock.sv
tb_prefetch.sv

// File: Makefile
# Verilator build and run for the prefetch unit testbench

VERILATOR ?= verilator
TOP       ?= tb_prefetch
FILELIST  ?= prefetch.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j $(JOBS)
SIM_ARGS  ?=

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
